// File: hw/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Rename lanes handled per cycle, which is also the number of free ports
`define RN_LANES 4

// Physical and architectural register file sizes
`define RN_PREGS 64
`define RN_AREGS 32

// Each lane allocates from its own bank of tags
// The first tag of every bank is reserved and never handed out
`define RN_BANK 16

// Tags per bank that hold architectural state after reset
`define RN_INIT_PER_BANK 8

`endif

// File: hw/rename_pkg.sv
`include "rename_defines.svh"

package rename_pkg;

	// =========================================================================
	// Register number types
	// =========================================================================

	// Physical register tag
	typedef logic [$clog2(`RN_PREGS)-1:0] preg_t;

	// Architectural register number
	typedef logic [$clog2(`RN_AREGS)-1:0] areg_t;

	// One bit per physical register, set when the tag may be allocated
	typedef logic [`RN_PREGS-1:0] pmask_t;

	// =========================================================================
	// Lane and port records
	// =========================================================================

	// A lane asking for a new physical register for its destination
	typedef struct packed {
		logic  valid;
		areg_t dest;
	} rename_req_t;

	// Result for one lane, with the tag it replaced so it can be freed later
	typedef struct packed {
		logic  valid;
		preg_t new_tag;
		preg_t old_tag;
	} rename_rsp_t;

	// One tag returned to the free pool
	typedef struct packed {
		logic  valid;
		preg_t tag;
	} free_req_t;

endpackage

// File: hw/bank_cursor.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module bank_cursor (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic              [`RN_LANES-1:0]    grant,
	input  logic              [`RN_LANES-1:0]    busy_req,
	output rename_pkg::preg_t [`RN_LANES-1:0]    cand
);

	// Offset of a tag inside its bank
	localparam int OFF_W = $clog2(`RN_BANK);
	typedef logic [OFF_W-1:0] off_t;

	// Offset zero is the reserved slot, so the search range is 1 up to the end
	localparam off_t OFF_FIRST = off_t'(1);
	localparam off_t OFF_LAST  = off_t'(`RN_BANK - 1);

	// Slots 1..RN_INIT_PER_BANK are owned by the reset mapping
	// so the first tag worth looking at sits just above them
	localparam off_t OFF_START = off_t'(`RN_INIT_PER_BANK + 1);

	off_t [`RN_LANES-1:0] off_q;
	off_t [`RN_LANES-1:0] off_nxt;

	// =========================================================================
	// Offset update
	// =========================================================================

	// A granted lane moves on to the next slot
	// A busy lane also moves on, so it keeps hunting for a free tag while stalled
	// Lanes that neither won nor waited keep their candidate
	always_comb begin
		for (int i = 0; i < `RN_LANES; i++) begin
			off_nxt[i] = off_q[i];
			if (grant[i] || busy_req[i]) begin
				// Step over the reserved slot when wrapping
				if (off_q[i] == OFF_LAST)
					off_nxt[i] = OFF_FIRST;
				else
					off_nxt[i] = off_q[i] + OFF_FIRST;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `RN_LANES; i++)
				off_q[i] <= OFF_START;
		end else begin
			off_q <= off_nxt;
		end
	end

	// =========================================================================
	// Candidate tags
	// =========================================================================

	// Lane i always draws from bank i, so the tag is bank base plus offset
	always_comb begin
		for (int i = 0; i < `RN_LANES; i++)
			cand[i] = rename_pkg::preg_t'(i * `RN_BANK + int'(off_q[i]));
	end

endmodule

// File: hw/reg_freelist.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module reg_freelist (
	input  logic                                   clk,
	input  logic                                   rst,
	input  rename_pkg::rename_req_t [`RN_LANES-1:0] req,
	input  rename_pkg::preg_t       [`RN_LANES-1:0] cand,
	input  rename_pkg::free_req_t   [`RN_LANES-1:0] free,
	input  logic                                   checkpoint,
	input  logic                                   restore,
	output logic                    [`RN_LANES-1:0] grant,
	output logic                    [`RN_LANES-1:0] busy_req,
	output logic                                   stall
);

	// Marks the first tag of every bank
	function automatic rename_pkg::pmask_t reserved_mask();
		rename_pkg::pmask_t m;
		for (int t = 0; t < `RN_PREGS; t++)
			m[t] = ((t % `RN_BANK) == 0);
		return m;
	endfunction

	// Tags above the reset-mapped slots of each bank start out available
	function automatic rename_pkg::pmask_t reset_mask();
		rename_pkg::pmask_t m;
		for (int t = 0; t < `RN_PREGS; t++)
			m[t] = ((t % `RN_BANK) > `RN_INIT_PER_BANK);
		return m;
	endfunction

	localparam rename_pkg::pmask_t RSV_MASK  = reserved_mask();
	localparam rename_pkg::pmask_t INIT_MASK = reset_mask();

	// Live availability and the copy taken at the last checkpoint
	rename_pkg::pmask_t avail_q;
	rename_pkg::pmask_t avail_nxt;
	rename_pkg::pmask_t saved_q;
	rename_pkg::pmask_t saved_nxt;

	// =========================================================================
	// Grant and stall
	// =========================================================================

	// A lane is busy when it asks and its candidate is still in use
	// During a restore nothing is judged, the bitmap is about to be replaced
	always_comb begin
		for (int i = 0; i < `RN_LANES; i++)
			busy_req[i] = req[i].valid && !avail_q[cand[i]] && !restore;
	end

	assign stall = |busy_req;

	// The group goes as a whole, so one busy lane holds back all of them
	always_comb begin
		for (int i = 0; i < `RN_LANES; i++)
			grant[i] = req[i].valid && !stall && !restore;
	end

	// =========================================================================
	// Next bitmaps
	// =========================================================================

	always_comb begin
		// Restore swaps in the saved copy, otherwise start from the live map
		avail_nxt = restore ? saved_q : avail_q;

		// Allocations use the bitmap as it was before this edge
		for (int i = 0; i < `RN_LANES; i++) begin
			if (grant[i])
				avail_nxt[cand[i]] = 1'b0;
		end

		// Frees land on top of whatever the live map became, restored or not
		for (int i = 0; i < `RN_LANES; i++) begin
			if (free[i].valid)
				avail_nxt[free[i].tag] = 1'b1;
		end
		avail_nxt = avail_nxt & ~RSV_MASK;

		// The saved copy also sees frees, since a freed tag stays free after a flush
		saved_nxt = saved_q;
		for (int i = 0; i < `RN_LANES; i++) begin
			if (free[i].valid)
				saved_nxt[free[i].tag] = 1'b1;
		end
		saved_nxt = saved_nxt & ~RSV_MASK;

		// A checkpoint records the state including this cycle's changes
		if (checkpoint)
			saved_nxt = avail_nxt;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			avail_q <= INIT_MASK;
			saved_q <= INIT_MASK;
		end else begin
			avail_q <= avail_nxt;
			saved_q <= saved_nxt;
		end
	end

endmodule

// File: hw/rename_map.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module rename_map (
	input  logic                                   clk,
	input  logic                                   rst,
	input  rename_pkg::rename_req_t [`RN_LANES-1:0] req,
	input  rename_pkg::preg_t       [`RN_LANES-1:0] cand,
	input  logic                    [`RN_LANES-1:0] grant,
	input  logic                                   checkpoint,
	input  logic                                   restore,
	output rename_pkg::preg_t       [`RN_LANES-1:0] old_tag
);

	// Reset owner of architectural register a
	// Registers are dealt round robin across the banks, skipping slot zero
	function automatic rename_pkg::preg_t reset_tag(int a);
		int bank;
		int slot;
		bank = a % `RN_LANES;
		slot = 1 + a / `RN_LANES;
		return rename_pkg::preg_t'(bank * `RN_BANK + slot);
	endfunction

	// Current map, its next value and the checkpoint copy
	rename_pkg::preg_t map_q     [0:`RN_AREGS-1];
	rename_pkg::preg_t map_nxt   [0:`RN_AREGS-1];
	rename_pkg::preg_t saved_q   [0:`RN_AREGS-1];

	// =========================================================================
	// Old tag lookup
	// =========================================================================

	// Start from the table, then let every earlier granted lane with the
	// same destination override it
	// Scanning upward leaves the highest such lane in place
	always_comb begin
		for (int k = 0; k < `RN_LANES; k++) begin
			old_tag[k] = map_q[req[k].dest];
			for (int j = 0; j < k; j++) begin
				if (grant[j] && (req[j].dest == req[k].dest))
					old_tag[k] = cand[j];
			end
		end
	end

	// =========================================================================
	// Map update
	// =========================================================================

	always_comb begin
		// Restore reloads the saved map, no lane is granted in that cycle
		for (int a = 0; a < `RN_AREGS; a++)
			map_nxt[a] = restore ? saved_q[a] : map_q[a];

		// Writes go in lane order, so the last lane naming a register wins
		for (int i = 0; i < `RN_LANES; i++) begin
			if (grant[i])
				map_nxt[req[i].dest] = cand[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int a = 0; a < `RN_AREGS; a++) begin
				map_q[a]   <= reset_tag(a);
				saved_q[a] <= reset_tag(a);
			end
		end else begin
			for (int a = 0; a < `RN_AREGS; a++) begin
				map_q[a] <= map_nxt[a];
				// The copy includes this cycle's writes
				if (checkpoint)
					saved_q[a] <= map_nxt[a];
			end
		end
	end

endmodule

// File: hw/reg_renamer_top.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module reg_renamer_top (
	input  logic                                   clk,
	input  logic                                   rst,
	input  rename_pkg::rename_req_t [`RN_LANES-1:0] req,
	input  rename_pkg::free_req_t   [`RN_LANES-1:0] free,
	input  logic                                   checkpoint,
	input  logic                                   restore,
	output logic                                   stall,
	output rename_pkg::rename_rsp_t [`RN_LANES-1:0] rsp
);

	logic              [`RN_LANES-1:0] grant;
	logic              [`RN_LANES-1:0] busy_req;
	rename_pkg::preg_t [`RN_LANES-1:0] cand;
	rename_pkg::preg_t [`RN_LANES-1:0] old_tag;

	// =========================================================================
	// Datapath blocks
	// =========================================================================

	// Candidate tags, one per lane from that lane's bank
	bank_cursor i_bank_cursor (
		.clk      (clk),
		.rst      (rst),
		.grant    (grant),
		.busy_req (busy_req),
		.cand     (cand)
	);

	// Decides if the group may proceed and tracks which tags are in use
	reg_freelist i_reg_freelist (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.cand       (cand),
		.free       (free),
		.checkpoint (checkpoint),
		.restore    (restore),
		.grant      (grant),
		.busy_req   (busy_req),
		.stall      (stall)
	);

	// Records the new owners and reports the tags they displaced
	rename_map i_rename_map (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.cand       (cand),
		.grant      (grant),
		.checkpoint (checkpoint),
		.restore    (restore),
		.old_tag    (old_tag)
	);

	// =========================================================================
	// Response register
	// =========================================================================

	// Each lane reports whether it was granted, the tag it got and the tag it displaced
	always_ff @(posedge clk) begin
		for (int i = 0; i < `RN_LANES; i++) begin
			if (rst)
				rsp[i].valid <= 1'b0;
			else
				rsp[i].valid <= grant[i];
			rsp[i].new_tag <= cand[i];
			rsp[i].old_tag <= old_tag[i];
		end
	end

endmodule

// File: tests/tb_reg_renamer.sv
`timescale 1ns/1ps
`include "rename_defines.svh"

module tb_reg_renamer;

	localparam int N_CYCLES    = 3000;
	localparam int CLK_PERIOD  = 8;
	// A group stuck this long is flushed so the random run keeps moving
	localparam int STALL_LIMIT = 24;

	logic clk;
	logic rst;
	logic checkpoint;
	logic restore;
	logic stall;
	rename_pkg::rename_req_t [`RN_LANES-1:0] req;
	rename_pkg::free_req_t   [`RN_LANES-1:0] free;
	rename_pkg::rename_rsp_t [`RN_LANES-1:0] rsp;

	// Reference model of map, bitmaps and cursors, plus the response due next cycle
	rename_pkg::preg_t       m_map       [`RN_AREGS];
	rename_pkg::preg_t       m_saved_map [`RN_AREGS];
	// Map as it stood in the cycle the pending response was granted
	rename_pkg::preg_t       m_prev_map  [`RN_AREGS];
	rename_pkg::pmask_t      m_avail;
	rename_pkg::pmask_t      m_saved_avail;
	logic [3:0]              m_off       [`RN_LANES];
	logic                    m_stall;
	int                      stall_run;
	rename_pkg::rename_rsp_t [`RN_LANES-1:0] exp_rsp;
	// Displaced tags waiting to be handed back
	rename_pkg::preg_t       free_pool [$];
	logic [31:0]             rng;

	reg_renamer_top i_reg_renamer_top (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.free       (free),
		.checkpoint (checkpoint),
		.restore    (restore),
		.stall      (stall),
		.rsp        (rsp)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// =========================================================================
	// Helpers
	// =========================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic logic tag_mapped(input rename_pkg::preg_t t, input logic in_saved);
		for (int a = 0; a < `RN_AREGS; a++) begin
			if (in_saved ? (m_saved_map[a] == t) : (m_map[a] == t))
				return 1'b1;
		end
		return 1'b0;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp, act);
		$display("[FAIL] %s expected %0d actual %0d", name, exp, act);
		$display("SIMULATION FAILED");
		$fatal(1, "value mismatch");
	endtask

	task automatic report_error(input string what);
		$display("ERROR: %s", what);
		$display("SIMULATION FAILED");
		$fatal(1, "check failed");
	endtask

	// Register a sits in bank a mod 4 at slot 1 + a/4, everything else is free
	task automatic reset_model();
		m_avail = '1;
		for (int t = 0; t < `RN_PREGS; t += `RN_BANK)
			m_avail[t] = 1'b0;
		for (int a = 0; a < `RN_AREGS; a++) begin
			m_map[a] = rename_pkg::preg_t'((a % `RN_LANES) * `RN_BANK + 1 + a / `RN_LANES);
			m_saved_map[a] = m_map[a];
			m_prev_map[a] = m_map[a];
			m_avail[m_map[a]] = 1'b0;
		end
		m_saved_avail = m_avail;
		for (int i = 0; i < `RN_LANES; i++)
			m_off[i] = 4'(`RN_INIT_PER_BANK + 1);
		m_stall = 1'b0;
		stall_run = 0;
		exp_rsp = '0;
	endtask

	// =========================================================================
	// Stimulus
	// =========================================================================

	task automatic drive_cycle();
		rename_pkg::rename_req_t [`RN_LANES-1:0] r;
		rename_pkg::free_req_t   [`RN_LANES-1:0] f;
		rename_pkg::preg_t t;
		int idx;
		logic dup;
		r = req;
		f = '0;
		// A group that stalled last cycle is held as it was
		if (!m_stall) begin
			for (int i = 0; i < `RN_LANES; i++) begin
				r[i].valid = (next_rand() % 8) < 5;
				// Reusing the previous lane's dest exercises chaining
				if (i > 0 && (next_rand() % 4) == 0)
					r[i].dest = r[i-1].dest;
				else
					r[i].dest = rename_pkg::areg_t'(next_rand());
			end
		end
		// Only tags that are neither live nor mapped at the checkpoint may go back
		for (int i = 0; i < `RN_LANES; i++) begin
			if (free_pool.size() > 0 && (next_rand() % 2) == 0) begin
				idx = int'(next_rand() % free_pool.size());
				t = free_pool[idx];
				dup = 1'b0;
				for (int j = 0; j < i; j++)
					dup |= f[j].valid && (f[j].tag == t);
				if (m_avail[t] || tag_mapped(t, 1'b0)) begin
					free_pool.delete(idx);
				end else if (!dup && !tag_mapped(t, 1'b1)) begin
					f[i].valid = 1'b1;
					f[i].tag = t;
					free_pool.delete(idx);
				end
			end
		end
		req <= r;
		free <= f;
		checkpoint <= (next_rand() % 32) == 0;
		restore <= ((next_rand() % 64) == 0) || (stall_run >= STALL_LIMIT);
	endtask

	// =========================================================================
	// Reference model and checks
	// =========================================================================

	task automatic check_rsp();
		logic mapped;
		for (int i = 0; i < `RN_LANES; i++) begin
			assert (rsp[i].valid === exp_rsp[i].valid)
				else report_mismatch($sformatf("rsp[%0d].valid", i),
					exp_rsp[i].valid, rsp[i].valid);
			if (exp_rsp[i].valid) begin
				// A granted tag is never a reserved slot and was owned by no register
				mapped = 1'b0;
				for (int a = 0; a < `RN_AREGS; a++)
					mapped |= (m_prev_map[a] === rsp[i].new_tag);
				assert ((rsp[i].new_tag % `RN_BANK) != 0)
					else report_error($sformatf("lane %0d was given a reserved tag", i));
				assert (!mapped)
					else report_error($sformatf("tag %0d granted while still mapped",
						rsp[i].new_tag));
				assert (rsp[i].new_tag === exp_rsp[i].new_tag)
					else report_mismatch($sformatf("rsp[%0d].new_tag", i),
						exp_rsp[i].new_tag, rsp[i].new_tag);
				assert (rsp[i].old_tag === exp_rsp[i].old_tag)
					else report_mismatch($sformatf("rsp[%0d].old_tag", i),
						exp_rsp[i].old_tag, rsp[i].old_tag);
			end
		end
	endtask

	task automatic model_step();
		rename_pkg::preg_t  c     [`RN_LANES];
		rename_pkg::preg_t  old_t [`RN_LANES];
		rename_pkg::preg_t  work  [`RN_AREGS];
		rename_pkg::pmask_t nav;
		rename_pkg::pmask_t nsav;
		logic [`RN_LANES-1:0] busy;
		logic [`RN_LANES-1:0] gnt;
		logic stl;
		for (int i = 0; i < `RN_LANES; i++) begin
			c[i] = rename_pkg::preg_t'(i * `RN_BANK + m_off[i]);
			busy[i] = req[i].valid && !m_avail[c[i]] && !restore;
		end
		stl = |busy;
		gnt = '0;
		for (int i = 0; i < `RN_LANES; i++)
			gnt[i] = req[i].valid && !stl && !restore;
		assert (stall === stl) else report_mismatch("stall", stl, stall);
		// Lanes write a scratch map in order, so each sees the latest earlier writer
		for (int a = 0; a < `RN_AREGS; a++)
			work[a] = restore ? m_saved_map[a] : m_map[a];
		for (int k = 0; k < `RN_LANES; k++) begin
			old_t[k] = work[req[k].dest];
			if (gnt[k]) begin
				work[req[k].dest] = c[k];
				free_pool.push_back(old_t[k]);
			end
		end
		nav = restore ? m_saved_avail : m_avail;
		nsav = m_saved_avail;
		for (int i = 0; i < `RN_LANES; i++) begin
			if (gnt[i])
				nav[c[i]] = 1'b0;
		end
		for (int i = 0; i < `RN_LANES; i++) begin
			if (free[i].valid && (free[i].tag % `RN_BANK) != 0) begin
				nav[free[i].tag] = 1'b1;
				nsav[free[i].tag] = 1'b1;
			end
		end
		if (checkpoint) begin
			nsav = nav;
			m_saved_map = work;
		end
		m_prev_map = m_map;
		m_map = work;
		m_avail = nav;
		m_saved_avail = nsav;
		for (int i = 0; i < `RN_LANES; i++) begin
			if (gnt[i] || busy[i])
				m_off[i] = (m_off[i] == 4'd15) ? 4'd1 : m_off[i] + 4'd1;
			exp_rsp[i].valid = gnt[i];
			exp_rsp[i].new_tag = c[i];
			exp_rsp[i].old_tag = old_t[i];
		end
		m_stall = stl;
		stall_run = stl ? stall_run + 1 : 0;
	endtask

	// =========================================================================
	// Main sequence and watchdog
	// =========================================================================

	initial begin
		rng = 32'd46;
		rst = 1'b1;
		req = '0;
		free = '0;
		checkpoint = 1'b0;
		restore = 1'b0;
		reset_model();
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (stall === 1'b0) else report_mismatch("reset stall", 0, stall);
		check_rsp();
		// Inputs change on the rising edge, results are read on the falling edge
		for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
			@(posedge clk);
			drive_cycle();
			@(negedge clk);
			check_rsp();
			model_step();
		end
		$display("SIMULATION PASSED");
		$finish;
	end

	initial begin
		#((N_CYCLES + 100) * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", N_CYCLES + 100);
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: verilog.f
+incdir+hw
hw/rename_pkg.sv
hw/bank_cursor.sv
hw/reg_freelist.sv
hw/rename_map.sv
hw/reg_renamer_top.sv
tests/tb_reg_renamer.sv

// File: Bender.yml
package:
  name: reg_renamer

sources:
  - include_dirs:
      - hw
    files:
      - hw/rename_pkg.sv
      - hw/bank_cursor.sv
      - hw/reg_freelist.sv
      - hw/rename_map.sv
      - hw/reg_renamer_top.sv
      - target: test
        files:
          - tests/tb_reg_renamer.sv
